// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = tb_desc_processor
FILELIST  = all.f
OBJDIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)

// File: all.f
common/desc_pkg.sv
common/lite_req_if.sv
irq/irq_event_counter.sv
irq/irq_handler_fsm.sv
irq/pcie_irq_clear.sv
hw/reg_write_feeder.sv
hw/lite_arbiter.sv
hw/desc_processor.sv
dv/lite_bus_model.sv
dv/tb_desc_processor.sv

// File: common/desc_pkg.sv
`default_nettype none

package desc_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Wrapping interrupt event count
    typedef logic [2:0] irq_count_t;

    // Lite bus operations
    typedef enum logic {
        op_single_rd,
        op_single_wr
    } lite_op_e;

    // ----------------------------------------------------------
    // PCIe root controller registers
    // ----------------------------------------------------------
    localparam addr_t PCIECTL_BASE_ADDR     = 32'h5000_0000;
    localparam addr_t PCIECTL_INT_DECODE    = 32'h0000_0138;
    localparam addr_t PCIECTL_INT_FIFO_REG1 = 32'h0000_0158;

    localparam data_t PIRQ_DECODE_CLEAR = 32'h0001_0000;
    localparam data_t PIRQ_FIFO_CLEAR   = 32'hffff_ffff;

    // ----------------------------------------------------------
    // MAC interrupt status registers
    // ----------------------------------------------------------
    localparam addr_t ATH9K_BASE_ADDR = 32'h6000_0000;
    localparam addr_t AR_ISR          = 32'h0000_0080;
    // Read-to-clear alias of the ISR
    localparam addr_t AR_ISR_RAC      = 32'h0000_00c0;

    localparam data_t AR_ISR_HP_RXOK = 32'h0000_0001;
    localparam data_t AR_ISR_RXINTM  = 32'h8000_0000;
    localparam data_t AR_ISR_RXMINTR = 32'h0100_0000;

    // Receive pattern handled here instead of by the host
    localparam data_t ISR_OWNED_RX = AR_ISR_HP_RXOK | AR_ISR_RXINTM | AR_ISR_RXMINTR;

endpackage

`default_nettype wire

// File: common/lite_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lite_req_if;
    import desc_pkg::*;

    logic     req;
    lite_op_e op;
    addr_t    addr;
    data_t    wdata;
    // One-cycle grant pulse, aligned with lite_start
    logic     ack;

    modport requester (output req, output op, output addr, output wdata, input ack);

    modport arbiter (input req, input op, input addr, input wdata, output ack);

endinterface

`default_nettype wire

// File: dv/lite_bus_model.sv
`timescale 1ns/1ps
`default_nettype none

module lite_bus_model (
    input  logic               clk,
    input  logic               lite_start,
    input  desc_pkg::lite_op_e lite_op,
    input  desc_pkg::addr_t    lite_addr,
    input  desc_pkg::data_t    lite_wdata,
    output desc_pkg::data_t    lite_rdata,
    output logic               lite_done,
    input  desc_pkg::data_t    isr_value,
    input  logic               stall
);
    import desc_pkg::*;

    // One entry per started access: {is_write, addr, wdata}
    logic [64:0] txn_log[$];

    logic [31:0] rng;
    logic        busy;
    logic        start_seen;
    logic        hold;
    int          wait_cnt;
    data_t       resp_data;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rng        = 32'hcd22f123;
        busy       = 1'b0;
        wait_cnt   = 0;
        resp_data  = '0;
        lite_done  = 1'b0;
        lite_rdata = '0;
        forever begin
            @(posedge clk);
            // Bus outputs sampled on the edge
            start_seen = (lite_start === 1'b1);
            hold       = (stall === 1'b1);
            if (start_seen) begin
                txn_log.push_back({lite_op == op_single_wr, lite_addr, lite_wdata});
                if (lite_op == op_single_rd && lite_addr == ATH9K_BASE_ADDR + AR_ISR) begin
                    resp_data = isr_value;
                end else begin
                    resp_data = '0;
                end
            end
            #1;
            lite_done = 1'b0;
            if (start_seen) begin
                // Latency of 1 to 8 cycles
                rng      = xorshift32(rng);
                wait_cnt = int'(rng[2:0]) + 1;
                busy     = 1'b1;
            end else if (busy && !hold) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    busy       = 1'b0;
                    lite_done  = 1'b1;
                    lite_rdata = resp_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_desc_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_desc_processor;
    import desc_pkg::*;

    localparam int    WAIT_LIMIT   = 2000;
    localparam int    QUIET_CYCLES = 20;
    localparam int    NUM_PAIRS    = 6;
    localparam data_t OTHER_ISR    = 32'h0000_0020;

    logic     clk;
    logic     reset_n;
    logic     irq_in;
    logic     irq_out;
    logic     fifo_empty;
    logic     fifo_valid;
    data_t    fifo_dread;
    logic     fifo_rd_en;
    logic     lite_start;
    lite_op_e lite_op;
    addr_t    lite_addr;
    data_t    lite_wdata;
    data_t    lite_rdata;
    logic     lite_done;
    data_t    isr_value;
    logic     stall;

    data_t       fifo_q[$];
    int          fifo_rd_ptr;
    logic [31:0] rng;
    int          log_base;
    int          errors;
    int          monitor_errors;
    int          timeouts;
    int          checks;
    logic        forbid_irq_out;
    logic        start_prev;
    logic        in_flight;

    desc_processor uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .irq_in     (irq_in),
        .irq_out    (irq_out),
        .fifo_empty (fifo_empty),
        .fifo_valid (fifo_valid),
        .fifo_dread (fifo_dread),
        .fifo_rd_en (fifo_rd_en),
        .lite_start (lite_start),
        .lite_op    (lite_op),
        .lite_addr  (lite_addr),
        .lite_wdata (lite_wdata),
        .lite_rdata (lite_rdata),
        .lite_done  (lite_done)
    );

    lite_bus_model u_bus_model (
        .clk        (clk),
        .lite_start (lite_start),
        .lite_op    (lite_op),
        .lite_addr  (lite_addr),
        .lite_wdata (lite_wdata),
        .lite_rdata (lite_rdata),
        .lite_done  (lite_done),
        .isr_value  (isr_value),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------------------------
    // FWFT FIFO model popping on the sampled read enable
    // ----------------------------------------------------------
    initial begin
        logic pop;
        fifo_rd_ptr = 0;
        fifo_empty  = 1'b1;
        fifo_valid  = 1'b0;
        fifo_dread  = '0;
        forever begin
            @(posedge clk);
            pop = (fifo_rd_en === 1'b1);
            #1;
            if (pop && fifo_rd_ptr < fifo_q.size()) begin
                fifo_rd_ptr = fifo_rd_ptr + 1;
            end
            fifo_empty = (fifo_rd_ptr >= fifo_q.size());
            fifo_valid = !fifo_empty;
            fifo_dread = fifo_empty ? '0 : fifo_q[fifo_rd_ptr];
        end
    end

    task automatic print_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // ----------------------------------------------------------
    // Bus protocol monitor
    // ----------------------------------------------------------
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_prev <= 1'b0;
            in_flight  <= 1'b0;
        end else begin
            start_prev <= lite_start;
            if (lite_start) begin
                in_flight <= 1'b1;
            end else if (lite_done) begin
                in_flight <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset_n === 1'b1) begin
            if (start_prev) begin
                assert (!lite_start) else begin
                    monitor_errors++;
                    print_error("lite_start held for more than one cycle");
                end
            end
            if (lite_start && !start_prev) begin
                assert (!in_flight) else begin
                    monitor_errors++;
                    print_error("lite_start before lite_done of the previous access");
                end
            end
            if (forbid_irq_out) begin
                assert (!irq_out) else begin
                    monitor_errors++;
                    print_error("irq_out raised for an owned interrupt");
                end
            end
        end
    end

    task automatic push_pair(input addr_t addr, input data_t data);
        fifo_q.push_back(addr);
        fifo_q.push_back(data);
    endtask

    task automatic check_idle_outputs();
        checks++;
        assert (irq_out === 1'b0 && fifo_rd_en === 1'b0 && lite_start === 1'b0) else begin
            errors++;
            print_error($sformatf("outputs not idle: irq_out %b fifo_rd_en %b lite_start %b",
                                  irq_out, fifo_rd_en, lite_start));
        end
    endtask

    // Reads are checked on op and address only
    task automatic check_txn(input int idx, input logic exp_wr, input addr_t exp_addr,
                             input data_t exp_data, input string what);
        logic [64:0] got;
        checks++;
        if (log_base + idx >= u_bus_model.txn_log.size()) begin
            errors++;
            print_error($sformatf("%s missing at index %0d", what, idx));
        end else begin
            got = u_bus_model.txn_log[log_base + idx];
            assert (got[64] == exp_wr && got[63:32] == exp_addr
                    && (!exp_wr || got[31:0] == exp_data)) else begin
                errors++;
                print_error($sformatf("%s expected wr %0b addr %h data %h, got wr %0b addr %h data %h",
                                      what, exp_wr, exp_addr, exp_data,
                                      got[64], got[63:32], got[31:0]));
            end
        end
    endtask

    task automatic check_log_size(input int exp_count, input string what);
        checks++;
        assert (u_bus_model.txn_log.size() - log_base == exp_count) else begin
            errors++;
            print_error($sformatf("%s expected %0d accesses, got %0d", what, exp_count,
                                  u_bus_model.txn_log.size() - log_base));
        end
    endtask

    // ----------------------------------------------------------
    // Bounded waits
    // ----------------------------------------------------------
    task automatic wait_log(input int count, input string what);
        int cycles;
        cycles = 0;
        while (u_bus_model.txn_log.size() - log_base < count && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (u_bus_model.txn_log.size() - log_base < count) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic wait_irq_out(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (irq_out !== level && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (irq_out !== level) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic wait_feed_request();
        int cycles;
        cycles = 0;
        while (uut.feed_req.req !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (uut.feed_req.req !== 1'b1) begin
            timeouts++;
            $display("Timeout while waiting for the register write feeder to request the bus");
        end
    endtask

    task automatic wait_bus_quiet();
        int cycles;
        int idle;
        cycles = 0;
        idle   = 0;
        while (idle < QUIET_CYCLES && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (lite_start || in_flight) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (idle < QUIET_CYCLES) begin
            timeouts++;
            $display("Timeout while waiting for the lite bus to go quiet");
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        addr_t a;
        data_t d;
        addr_t exp_addr[$];
        data_t exp_data[$];
        int    n;
        reset_n        = 1'b0;
        irq_in         = 1'b0;
        isr_value      = '0;
        stall          = 1'b0;
        forbid_irq_out = 1'b0;
        errors         = 0;
        monitor_errors = 0;
        timeouts       = 0;
        checks         = 0;
        log_base       = 0;
        rng            = 32'hcd22f123;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        repeat (4) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end

        // Register writes in FIFO order
        for (int i = 0; i < NUM_PAIRS; i++) begin
            rng = xorshift32(rng);
            a   = rng;
            rng = xorshift32(rng);
            d   = rng;
            exp_addr.push_back(a);
            exp_data.push_back(d);
            push_pair(a, d);
        end
        wait_log(NUM_PAIRS, "register writes from the FIFO");
        wait_bus_quiet();
        check_log_size(NUM_PAIRS, "FIFO writes");
        for (int i = 0; i < NUM_PAIRS; i++) begin
            check_txn(i, 1'b1, exp_addr[i], exp_data[i], "FIFO register write");
        end

        // Owned RX interrupt with irq_in held over two clear rounds
        log_base       = u_bus_model.txn_log.size();
        isr_value      = ISR_OWNED_RX;
        forbid_irq_out = 1'b1;
        irq_in         = 1'b1;
        wait_log(6, "two rounds of PCIe clearing writes");
        irq_in = 1'b0;
        wait_bus_quiet();
        forbid_irq_out = 1'b0;
        check_txn(0, 1'b0, ATH9K_BASE_ADDR + AR_ISR, '0, "ISR read");
        check_txn(1, 1'b0, ATH9K_BASE_ADDR + AR_ISR_RAC, '0, "ISR read-to-clear");
        n = u_bus_model.txn_log.size() - log_base;
        checks++;
        assert (n >= 6 && n % 2 == 0) else begin
            errors++;
            print_error($sformatf("owned interrupt gave %0d accesses", n));
        end
        for (int i = 2; i + 1 < n; i += 2) begin
            check_txn(i, 1'b1, PCIECTL_BASE_ADDR + PCIECTL_INT_DECODE, PIRQ_DECODE_CLEAR,
                      "decode clear write");
            check_txn(i + 1, 1'b1, PCIECTL_BASE_ADDR + PCIECTL_INT_FIFO_REG1, PIRQ_FIFO_CLEAR,
                      "FIFO register clear write");
        end

        // Foreign ISR value goes to the host
        log_base  = u_bus_model.txn_log.size();
        isr_value = OTHER_ISR;
        irq_in    = 1'b1;
        wait_irq_out(1'b1, WAIT_LIMIT, "irq_out to rise");
        irq_in = 1'b0;
        wait_irq_out(1'b0, 4, "irq_out to fall after irq_in");
        wait_bus_quiet();
        check_log_size(1, "passed interrupt");
        check_txn(0, 1'b0, ATH9K_BASE_ADDR + AR_ISR, '0, "ISR read");

        // Feeder write and interrupt handler both waiting behind a held ISR read
        log_base       = u_bus_model.txn_log.size();
        isr_value      = ISR_OWNED_RX;
        forbid_irq_out = 1'b1;
        stall          = 1'b1;
        irq_in         = 1'b1;
        wait_log(1, "held ISR read");
        rng = xorshift32(rng);
        a   = rng;
        rng = xorshift32(rng);
        d   = rng;
        push_pair(a, d);
        wait_feed_request();
        stall = 1'b0;
        wait_log(3, "accesses after the held read");
        irq_in = 1'b0;
        wait_bus_quiet();
        forbid_irq_out = 1'b0;
        check_log_size(5, "priority sequence");
        check_txn(0, 1'b0, ATH9K_BASE_ADDR + AR_ISR, '0, "held ISR read");
        check_txn(1, 1'b0, ATH9K_BASE_ADDR + AR_ISR_RAC, '0, "ISR read-to-clear at next grant");
        check_txn(2, 1'b1, a, d, "pending write");
        check_txn(3, 1'b1, PCIECTL_BASE_ADDR + PCIECTL_INT_DECODE, PIRQ_DECODE_CLEAR,
                  "decode clear write");
        check_txn(4, 1'b1, PCIECTL_BASE_ADDR + PCIECTL_INT_FIFO_REG1, PIRQ_FIFO_CLEAR,
                  "FIFO register clear write");

        $display("Checks: %0d, errors: %0d, monitor errors: %0d, timeouts: %0d",
                 checks, errors, monitor_errors, timeouts);
        if (errors == 0 && monitor_errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/desc_processor.sv
`timescale 1ns/1ps
`default_nettype none

module desc_processor (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               irq_in,
    output logic               irq_out,
    input  logic               fifo_empty,
    input  logic               fifo_valid,
    input  desc_pkg::data_t    fifo_dread,
    output logic               fifo_rd_en,
    output logic               lite_start,
    output desc_pkg::lite_op_e lite_op,
    output desc_pkg::addr_t    lite_addr,
    output desc_pkg::data_t    lite_wdata,
    input  desc_pkg::data_t    lite_rdata,
    input  logic               lite_done
);

    logic take;
    logic pending;
    logic pirq_start;
    logic pirq_done;

    // One request channel per bus master
    lite_req_if irq_req ();
    lite_req_if feed_req ();
    lite_req_if pirq_req ();

    // ----------------------------------------------------------
    // Interrupt path
    // ----------------------------------------------------------
    irq_event_counter u_irq_event_counter (
        .clk     (clk),
        .reset_n (reset_n),
        .irq_in  (irq_in),
        .take    (take),
        .pending (pending)
    );

    irq_handler_fsm u_irq_handler_fsm (
        .clk        (clk),
        .reset_n    (reset_n),
        .irq_in     (irq_in),
        .pending    (pending),
        .take       (take),
        .lite_rdata (lite_rdata),
        .lite_done  (lite_done),
        .bus        (irq_req.requester),
        .pirq_start (pirq_start),
        .pirq_done  (pirq_done),
        .irq_out    (irq_out)
    );

    pcie_irq_clear u_pcie_irq_clear (
        .clk        (clk),
        .reset_n    (reset_n),
        .irq_in     (irq_in),
        .pirq_start (pirq_start),
        .pirq_done  (pirq_done),
        .lite_done  (lite_done),
        .bus        (pirq_req.requester)
    );

    // ----------------------------------------------------------
    // Register writes and bus access
    // ----------------------------------------------------------
    reg_write_feeder u_reg_write_feeder (
        .clk        (clk),
        .reset_n    (reset_n),
        .fifo_empty (fifo_empty),
        .fifo_valid (fifo_valid),
        .fifo_dread (fifo_dread),
        .fifo_rd_en (fifo_rd_en),
        .lite_done  (lite_done),
        .bus        (feed_req.requester)
    );

    lite_arbiter u_lite_arbiter (
        .clk        (clk),
        .reset_n    (reset_n),
        .irq_bus    (irq_req.arbiter),
        .feed_bus   (feed_req.arbiter),
        .pirq_bus   (pirq_req.arbiter),
        .lite_start (lite_start),
        .lite_op    (lite_op),
        .lite_addr  (lite_addr),
        .lite_wdata (lite_wdata),
        .lite_done  (lite_done)
    );

endmodule

`default_nettype wire

// File: hw/lite_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module lite_arbiter (
    input  logic                clk,
    input  logic                reset_n,
    lite_req_if.arbiter         irq_bus,
    lite_req_if.arbiter         feed_bus,
    lite_req_if.arbiter         pirq_bus,
    output logic                lite_start,
    output desc_pkg::lite_op_e  lite_op,
    output desc_pkg::addr_t     lite_addr,
    output desc_pkg::data_t     lite_wdata,
    input  logic                lite_done
);
    import desc_pkg::*;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_e;

    arb_state_e state;
    logic [2:0] grant;
    logic [2:0] ack_q;
    lite_op_e   sel_op;
    addr_t      sel_addr;
    data_t      sel_wdata;

    // ----------------------------------------------------------
    // Fixed priority: irq handler, feeder, PCIe clear
    // ----------------------------------------------------------
    always_comb begin
        grant     = 3'b000;
        sel_op    = irq_bus.op;
        sel_addr  = irq_bus.addr;
        sel_wdata = irq_bus.wdata;
        if (irq_bus.req) begin
            grant = 3'b001;
        end else if (feed_bus.req) begin
            grant     = 3'b010;
            sel_op    = feed_bus.op;
            sel_addr  = feed_bus.addr;
            sel_wdata = feed_bus.wdata;
        end else if (pirq_bus.req) begin
            grant     = 3'b100;
            sel_op    = pirq_bus.op;
            sel_addr  = pirq_bus.addr;
            sel_wdata = pirq_bus.wdata;
        end
    end

    // Start and ack go out together, one cycle after the grant
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= arb_idle;
            lite_start <= 1'b0;
            ack_q      <= 3'b000;
        end else begin
            lite_start <= 1'b0;
            ack_q      <= 3'b000;
            case (state)
                arb_idle: begin
                    if (grant != 3'b000) begin
                        lite_start <= 1'b1;
                        ack_q      <= grant;
                        state      <= arb_busy;
                    end
                end
                arb_busy: if (lite_done) state <= arb_idle;
                default:  state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == arb_idle && grant != 3'b000) begin
            lite_op    <= sel_op;
            lite_addr  <= sel_addr;
            lite_wdata <= sel_wdata;
        end
    end

    assign irq_bus.ack  = ack_q[0];
    assign feed_bus.ack = ack_q[1];
    assign pirq_bus.ack = ack_q[2];

endmodule

`default_nettype wire

// File: hw/reg_write_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module reg_write_feeder (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            fifo_empty,
    input  logic            fifo_valid,
    input  desc_pkg::data_t fifo_dread,
    output logic            fifo_rd_en,
    input  logic            lite_done,
    lite_req_if.requester   bus
);
    import desc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_pop_addr,
        st_wait_data,
        st_req,
        st_wait_done
    } feed_state_e;

    feed_state_e state;
    addr_t       addr_q;
    data_t       data_q;
    logic        word_avail;

    // FWFT head word is usable
    assign word_avail = fifo_valid && !fifo_empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= st_idle;
            fifo_rd_en <= 1'b0;
        end else begin
            fifo_rd_en <= 1'b0;
            case (state)
                st_idle: begin
                    if (word_avail) begin
                        fifo_rd_en <= 1'b1;
                        state      <= st_pop_addr;
                    end
                end
                // Head still shows the address word while the pop completes
                st_pop_addr: state <= st_wait_data;
                st_wait_data: begin
                    if (word_avail) begin
                        fifo_rd_en <= 1'b1;
                        state      <= st_req;
                    end
                end
                st_req:       if (bus.ack) state <= st_wait_done;
                st_wait_done: if (lite_done) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Address and data words of the pair
    always_ff @(posedge clk) begin
        if (state == st_idle && word_avail) begin
            addr_q <= fifo_dread;
        end
        if (state == st_wait_data && word_avail) begin
            data_q <= fifo_dread;
        end
    end

    assign bus.req   = (state == st_req);
    assign bus.op    = op_single_wr;
    assign bus.addr  = addr_q;
    assign bus.wdata = data_q;

endmodule

`default_nettype wire

// File: irq/irq_event_counter.sv
`timescale 1ns/1ps
`default_nettype none

module irq_event_counter (
    input  logic clk,
    input  logic reset_n,
    input  logic irq_in,
    input  logic take,
    output logic pending
);
    import desc_pkg::*;

    logic       irq_meta;
    logic       irq_sync;
    logic       irq_prev;
    irq_count_t event_cnt;
    irq_count_t served_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_meta   <= 1'b0;
            irq_sync   <= 1'b0;
            irq_prev   <= 1'b0;
            event_cnt  <= '0;
            served_cnt <= '0;
        end else begin
            // Two-flop synchronizer, third flop for edge detect
            irq_meta <= irq_in;
            irq_sync <= irq_meta;
            irq_prev <= irq_sync;
            if (irq_sync && !irq_prev) begin
                event_cnt <= event_cnt + 1'b1;
            end
            if (take) begin
                served_cnt <= event_cnt;
            end
        end
    end

    // Counts differ while some interrupt is not yet served
    assign pending = (event_cnt != served_cnt);

endmodule

`default_nettype wire

// File: irq/irq_handler_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module irq_handler_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 irq_in,
    input  logic                 pending,
    output logic                 take,
    input  desc_pkg::data_t      lite_rdata,
    input  logic                 lite_done,
    lite_req_if.requester        bus,
    output logic                 pirq_start,
    input  logic                 pirq_done,
    output logic                 irq_out
);
    import desc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_rd_isr_req,
        st_rd_isr_wait,
        st_clr_all_req,
        st_clr_all_wait,
        st_pirq_wait,
        st_pass
    } irq_state_e;

    irq_state_e state;

    // ----------------------------------------------------------
    // Interrupt FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= st_idle;
            take       <= 1'b0;
            pirq_start <= 1'b0;
        end else begin
            take       <= 1'b0;
            pirq_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (irq_in && pending) begin
                        take  <= 1'b1;
                        state <= st_rd_isr_req;
                    end
                end
                st_rd_isr_req: begin
                    if (bus.ack) begin
                        state <= st_rd_isr_wait;
                    end
                end
                st_rd_isr_wait: begin
                    if (lite_done) begin
                        // Owned RX pattern is cleared here, anything else goes to the host
                        if (lite_rdata == ISR_OWNED_RX) begin
                            state <= st_clr_all_req;
                        end else begin
                            state <= st_pass;
                        end
                    end
                end
                st_clr_all_req: begin
                    if (bus.ack) begin
                        state <= st_clr_all_wait;
                    end
                end
                st_clr_all_wait: begin
                    if (lite_done) begin
                        pirq_start <= 1'b1;
                        state      <= st_pirq_wait;
                    end
                end
                st_pirq_wait: begin
                    if (pirq_done) begin
                        state <= st_idle;
                    end
                end
                st_pass: begin
                    if (!irq_in) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Both accesses are reads, the RAC read clears the ISR
    assign bus.req   = (state == st_rd_isr_req) || (state == st_clr_all_req);
    assign bus.op    = op_single_rd;
    assign bus.addr  = (state == st_clr_all_req) ? (ATH9K_BASE_ADDR + AR_ISR_RAC)
                                                 : (ATH9K_BASE_ADDR + AR_ISR);
    assign bus.wdata = '0;

    assign irq_out = (state == st_pass);

endmodule

`default_nettype wire

// File: irq/pcie_irq_clear.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_irq_clear (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          irq_in,
    input  logic          pirq_start,
    output logic          pirq_done,
    input  logic          lite_done,
    lite_req_if.requester bus
);
    import desc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_dec_req,
        st_dec_wait,
        st_fifo_req,
        st_fifo_wait
    } pirq_state_e;

    pirq_state_e state;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_idle;
            pirq_done <= 1'b0;
        end else begin
            pirq_done <= 1'b0;
            case (state)
                st_idle:      if (pirq_start) state <= st_dec_req;
                st_dec_req:   if (bus.ack) state <= st_dec_wait;
                st_dec_wait:  if (lite_done) state <= st_fifo_req;
                st_fifo_req:  if (bus.ack) state <= st_fifo_wait;
                st_fifo_wait: begin
                    if (lite_done) begin
                        // Controller still asserting, clear again
                        if (irq_in) begin
                            state <= st_dec_req;
                        end else begin
                            pirq_done <= 1'b1;
                            state     <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign bus.req   = (state == st_dec_req) || (state == st_fifo_req);
    assign bus.op    = op_single_wr;
    assign bus.addr  = (state == st_fifo_req) ? (PCIECTL_BASE_ADDR + PCIECTL_INT_FIFO_REG1)
                                              : (PCIECTL_BASE_ADDR + PCIECTL_INT_DECODE);
    assign bus.wdata = (state == st_fifo_req) ? PIRQ_FIFO_CLEAR : PIRQ_DECODE_CLEAR;

endmodule

`default_nettype wire
